// File: logic/ahb_ram_pkg.sv
// Shared sizes and types for the AHB-Lite RAM slave.
// Memory size is fixed here. It must be a power of two of at least 8 bytes.
// Only SINGLE/NONSEQ transfers are decoded. Burst, prot and lock feed parity only.
package ahb_ram_pkg;

    // Memory geometry
    localparam int MEM_BYTES = 4096;
    localparam int NUM_LANES = 4;
    localparam int MEM_WORDS = MEM_BYTES / NUM_LANES;
    localparam int WORD_AW   = $clog2(MEM_WORDS);

    // Bus field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int CHK_W  = 7;
    localparam int PAR_W  = 6;

    // HTRANS encoding, only NONSEQ starts a transfer here
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // HSIZE encoding up to one word
    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // Bus address
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [DATA_W-1:0] word_t;

    // Word index into both arrays
    typedef logic [WORD_AW-1:0] widx_t;

    // Byte enables, bit i covers bits 8*i+7 down to 8*i
    typedef logic [NUM_LANES-1:0] lanes_t;

    // Check code stored beside each word
    typedef logic [CHK_W-1:0] chk_t;

    // Address and control parity
    // bits 0..3 address bytes, bit 4 size/burst/prot/write/mastlock, bit 5 trans
    typedef logic [PAR_W-1:0] par_t;

    // Data-phase state, registered at the end of the address phase
    typedef struct packed {
        logic   active;
        logic   write;
        logic   err;
        widx_t  idx;
        lanes_t lanes;
    } phase_t;

endpackage

// File: logic/ahb_phase_ctrl.sv
// Address-phase front end of the RAM slave.
// Transfers are accepted on HSEL, HREADY and NONSEQ, or on a parity-bad HTRANS.
// Unaligned or oversized transfers are not checked. Sizes above a word act as word.
// Index bits above the memory size are ignored, so the memory aliases.
`timescale 1ns/1ps

module ahb_phase_ctrl (
    input  logic                s_clk_i,
    input  logic                s_resetn_i,

    input  ahb_ram_pkg::addr_t  haddr_i,
    input  logic [1:0]          htrans_i,
    input  logic [2:0]          hsize_i,
    input  logic [2:0]          hburst_i,
    input  logic [3:0]          hprot_i,
    input  logic                hwrite_i,
    input  logic                hmastlock_i,
    input  logic                hsel_i,
    input  ahb_ram_pkg::par_t   hparity_i,
    input  logic                hready_i,

    output ahb_ram_pkg::widx_t  ra_idx_o,
    output ahb_ram_pkg::phase_t ph_o
);
    import ahb_ram_pkg::*;

    par_t   s_parity;
    logic   s_par_err;
    logic   s_trans_bad;
    logic   s_transfer;
    logic   s_accept;
    widx_t  s_idx;
    lanes_t s_lanes;
    phase_t r_ph;

    // Even parity per protected group
    always_comb begin
        s_parity[0] = ^haddr_i[7:0];
        s_parity[1] = ^haddr_i[15:8];
        s_parity[2] = ^haddr_i[23:16];
        s_parity[3] = ^haddr_i[31:24];
        s_parity[4] = (^hsize_i) ^ (^hburst_i) ^ (^hprot_i) ^ hwrite_i ^ hmastlock_i;
        s_parity[5] = ^htrans_i;
    end

    assign s_par_err   = (s_parity != hparity_i);
    assign s_trans_bad = s_parity[5] ^ hparity_i[5];

    // A corrupted HTRANS cannot be trusted to mean IDLE,
    // so it is taken as a transfer and answered with ERROR
    assign s_transfer = s_trans_bad | (htrans_i == HTRANS_NONSEQ);

    // HREADY is low only in the first error cycle,
    // so nothing is accepted there and the second cycle sees a cleared phase
    assign s_accept = hsel_i & hready_i & s_transfer;

    assign s_idx    = haddr_i[WORD_AW+1:2];
    assign ra_idx_o = s_idx;

    // Byte lanes from size and low address bits
    always_comb begin
        case (hsize_i)
            HSIZE_BYTE: s_lanes = lanes_t'(1) << haddr_i[1:0];
            HSIZE_HALF: s_lanes = haddr_i[1] ? 4'b1100 : 4'b0011;
            default:    s_lanes = '1;
        endcase
    end

    always_ff @(posedge s_clk_i or negedge s_resetn_i) begin
        if (!s_resetn_i) begin
            r_ph <= '0;
        end else if (s_accept) begin
            r_ph.active <= 1'b1;
            // Bad parity never reaches the arrays
            r_ph.write  <= hwrite_i & ~s_par_err;
            r_ph.err    <= s_par_err;
            r_ph.idx    <= s_idx;
            r_ph.lanes  <= s_lanes;
        end else begin
            r_ph <= '0;
        end
    end

    assign ph_o = r_ph;

endmodule

// File: logic/ram_data_bank.sv
// Data word array with byte-lane writes.
// The read is launched with the address-phase index, so data is ready in the data phase.
// A read right behind a write to the same word is served from the forward register.
// The array has no reset. Words never written read as unknown.
`timescale 1ns/1ps

module ram_data_bank (
    input  logic                s_clk_i,
    input  logic                s_resetn_i,

    input  ahb_ram_pkg::widx_t  ra_idx_i,
    input  ahb_ram_pkg::phase_t ph_i,
    input  ahb_ram_pkg::word_t  hwdata_i,

    output ahb_ram_pkg::word_t  rdata_o
);
    import ahb_ram_pkg::*;

    word_t r_mem [MEM_WORDS];
    word_t r_rdata;

    // Last written word, kept for a read in the following data phase
    word_t r_fwd_word;
    widx_t r_fwd_idx;
    logic  r_fwd_vld;

    logic  s_fwd_hit;
    word_t s_wr_word;

    // Early read, every cycle
    always_ff @(posedge s_clk_i) begin
        r_rdata <= r_mem[ra_idx_i];
    end

    // The array read for this data phase was taken while the previous write
    // was still pending, so that write wins if the word matches
    assign s_fwd_hit = r_fwd_vld && (r_fwd_idx == ph_i.idx);
    assign rdata_o   = s_fwd_hit ? r_fwd_word : r_rdata;

    // Whole word after this write, for the forward path
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (ph_i.lanes[i]) begin
                s_wr_word[i*8 +: 8] = hwdata_i[i*8 +: 8];
            end else begin
                s_wr_word[i*8 +: 8] = rdata_o[i*8 +: 8];
            end
        end
    end

    // Lane writes at the end of the data phase
    always_ff @(posedge s_clk_i) begin
        if (ph_i.write) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (ph_i.lanes[i]) begin
                    r_mem[ph_i.idx][i*8 +: 8] <= hwdata_i[i*8 +: 8];
                end
            end
        end
    end

    // Forward valid only for the cycle right after a write
    always_ff @(posedge s_clk_i or negedge s_resetn_i) begin
        if (!s_resetn_i) begin
            r_fwd_vld <= 1'b0;
        end else begin
            r_fwd_vld <= ph_i.write;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (ph_i.write) begin
            r_fwd_word <= s_wr_word;
            r_fwd_idx  <= ph_i.idx;
        end
    end

endmodule

// File: logic/ram_check_bank.sv
// Check-code array, one code per data word.
// Any write replaces the whole code, whatever its size.
// The code is stored as given and never verified here.
`timescale 1ns/1ps

module ram_check_bank (
    input  logic                s_clk_i,
    input  logic                s_resetn_i,

    input  ahb_ram_pkg::widx_t  ra_idx_i,
    input  ahb_ram_pkg::phase_t ph_i,
    input  ahb_ram_pkg::chk_t   hwchk_i,

    output ahb_ram_pkg::chk_t   rchk_o
);
    import ahb_ram_pkg::*;

    chk_t  r_mem [MEM_WORDS];
    chk_t  r_rchk;

    chk_t  r_fwd_chk;
    widx_t r_fwd_idx;
    logic  r_fwd_vld;

    logic  s_fwd_hit;

    // Same early read as the data bank
    always_ff @(posedge s_clk_i) begin
        r_rchk <= r_mem[ra_idx_i];
    end

    assign s_fwd_hit = r_fwd_vld && (r_fwd_idx == ph_i.idx);
    assign rchk_o    = s_fwd_hit ? r_fwd_chk : r_rchk;

    always_ff @(posedge s_clk_i) begin
        if (ph_i.write) begin
            r_mem[ph_i.idx] <= hwchk_i;
        end
    end

    always_ff @(posedge s_clk_i or negedge s_resetn_i) begin
        if (!s_resetn_i) begin
            r_fwd_vld <= 1'b0;
        end else begin
            r_fwd_vld <= ph_i.write;
        end
    end

    // Code of the last write, for a read of the same word next cycle
    always_ff @(posedge s_clk_i) begin
        if (ph_i.write) begin
            r_fwd_chk <= hwchk_i;
            r_fwd_idx <= ph_i.idx;
        end
    end

endmodule

// File: logic/ahb_resp_merge.sv
// Response side of the RAM slave.
// Good transfers finish in one cycle. A parity error takes the two-cycle ERROR.
// HRDATA is zero outside the selected lanes and when no transfer is active.
`timescale 1ns/1ps

module ahb_resp_merge (
    input  logic                s_clk_i,
    input  logic                s_resetn_i,

    input  ahb_ram_pkg::phase_t ph_i,
    input  ahb_ram_pkg::word_t  rdata_i,
    input  ahb_ram_pkg::chk_t   rchk_i,

    output ahb_ram_pkg::word_t  hrdata_o,
    output ahb_ram_pkg::chk_t   hrchecksum_o,
    output logic                hready_o,
    output logic                hresp_o
);
    import ahb_ram_pkg::*;

    logic s_err_first;
    logic r_err_second;

    // Unselected lanes read as zero
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            hrdata_o[i*8 +: 8] = ph_i.lanes[i] ? rdata_i[i*8 +: 8] : 8'h00;
        end
    end

    // Code covers the whole word, so it is passed unmasked
    assign hrchecksum_o = rchk_i;

    // First ERROR cycle comes straight from the data-phase register
    assign s_err_first = ph_i.active & ph_i.err;

    // Second ERROR cycle
    always_ff @(posedge s_clk_i or negedge s_resetn_i) begin
        if (!s_resetn_i) begin
            r_err_second <= 1'b0;
        end else begin
            r_err_second <= s_err_first;
        end
    end

    // HRESP held over both cycles, HREADY low only in the first
    assign hready_o = ~s_err_first;
    assign hresp_o  = s_err_first | r_err_second;

endmodule

// File: logic/ahb_ram_top.sv
// AHB-Lite RAM slave with zero wait states and address/control parity.
// HREADY out is also used as the slave's own HREADY in.
// No HREADY input from the bus, so this assumes a single-slave or muxed-back system.
`timescale 1ns/1ps

module ahb_ram_top (
    input  logic               s_clk_i,
    input  logic               s_resetn_i,

    input  ahb_ram_pkg::addr_t haddr_i,
    input  ahb_ram_pkg::word_t hwdata_i,
    input  logic [2:0]         hburst_i,
    input  logic               hmastlock_i,
    input  logic [3:0]         hprot_i,
    input  logic [2:0]         hsize_i,
    input  logic [1:0]         htrans_i,
    input  logic               hwrite_i,
    input  logic               hsel_i,

    input  ahb_ram_pkg::par_t  hparity_i,
    input  ahb_ram_pkg::chk_t  hwchecksum_i,
    output ahb_ram_pkg::chk_t  hrchecksum_o,

    output ahb_ram_pkg::word_t hrdata_o,
    output logic               hready_o,
    output logic               hresp_o
);
    import ahb_ram_pkg::*;

    widx_t  ra_idx;
    phase_t ph;
    word_t  rdata;
    chk_t   rchk;

    ahb_phase_ctrl u_phase (
        .s_clk_i     (s_clk_i),
        .s_resetn_i  (s_resetn_i),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hsize_i     (hsize_i),
        .hburst_i    (hburst_i),
        .hprot_i     (hprot_i),
        .hwrite_i    (hwrite_i),
        .hmastlock_i (hmastlock_i),
        .hsel_i      (hsel_i),
        .hparity_i   (hparity_i),
        .hready_i    (hready_o),
        .ra_idx_o    (ra_idx),
        .ph_o        (ph)
    );

    ram_data_bank u_data (
        .s_clk_i    (s_clk_i),
        .s_resetn_i (s_resetn_i),
        .ra_idx_i   (ra_idx),
        .ph_i       (ph),
        .hwdata_i   (hwdata_i),
        .rdata_o    (rdata)
    );

    ram_check_bank u_check (
        .s_clk_i    (s_clk_i),
        .s_resetn_i (s_resetn_i),
        .ra_idx_i   (ra_idx),
        .ph_i       (ph),
        .hwchk_i    (hwchecksum_i),
        .rchk_o     (rchk)
    );

    ahb_resp_merge u_merge (
        .s_clk_i      (s_clk_i),
        .s_resetn_i   (s_resetn_i),
        .ph_i         (ph),
        .rdata_i      (rdata),
        .rchk_i       (rchk),
        .hrdata_o     (hrdata_o),
        .hrchecksum_o (hrchecksum_o),
        .hready_o     (hready_o),
        .hresp_o      (hresp_o)
    );

endmodule

// File: dv/tb_ahb_ram.sv
// Testbench for the AHB-Lite RAM slave.
// Single transfers plus back-to-back write/read pairs. Outputs are sampled at the falling edge.
// Only words written earlier are read back, since the arrays have no reset.
`timescale 1ns/1ps

module tb_ahb_ram;
    import ahb_ram_pkg::*;

    localparam int CLK_HALF_NS   = 2;
    // Transfers and idle cycles per test, in test order
    localparam int PLANNED_XFERS = 16 * 2 + 4 * 13 + 8 * 5 + 6 * 2 + 20 + 16;
    localparam int TIMEOUT_NS    = PLANNED_XFERS * 4 * 4 + 2000;

    logic       s_clk;
    logic       s_resetn;
    addr_t      haddr;
    word_t      hwdata;
    logic [2:0] hburst;
    logic       hmastlock;
    logic [3:0] hprot;
    logic [2:0] hsize;
    logic [1:0] htrans;
    logic       hwrite;
    logic       hsel;
    par_t       hparity;
    chk_t       hwchecksum;
    chk_t       hrchecksum;
    word_t      hrdata;
    logic       hready;
    logic       hresp;

    // Reference memory, bytes and one check code per word
    logic [7:0] mem_model [MEM_BYTES];
    chk_t       chk_model [MEM_WORDS];

    // Expected response for the current data-phase cycle
    logic  mon_en;
    logic  exp_rd;
    word_t exp_data;
    chk_t  exp_chk;
    logic  exp_ready;
    logic  exp_resp;

    int    seed = 28305;
    int    errors;
    int    checks;
    int    failed_tests;
    addr_t wr_addr [16];

    ahb_ram_top u_dut (
        .s_clk_i      (s_clk),
        .s_resetn_i   (s_resetn),
        .haddr_i      (haddr),
        .hwdata_i     (hwdata),
        .hburst_i     (hburst),
        .hmastlock_i  (hmastlock),
        .hprot_i      (hprot),
        .hsize_i      (hsize),
        .htrans_i     (htrans),
        .hwrite_i     (hwrite),
        .hsel_i       (hsel),
        .hparity_i    (hparity),
        .hwchecksum_i (hwchecksum),
        .hrchecksum_o (hrchecksum),
        .hrdata_o     (hrdata),
        .hready_o     (hready),
        .hresp_o      (hresp)
    );

    always #(CLK_HALF_NS) s_clk = ~s_clk;

    // Even parity per group, as the bus protection defines it
    function automatic par_t calc_parity(addr_t a, logic [1:0] tr, logic [2:0] sz,
                                         logic [2:0] bu, logic [3:0] pr, logic wr,
                                         logic lk);
        par_t p;
        p[0] = ^a[7:0];
        p[1] = ^a[15:8];
        p[2] = ^a[23:16];
        p[3] = ^a[31:24];
        p[4] = (^sz) ^ (^bu) ^ (^pr) ^ wr ^ lk;
        p[5] = ^tr;
        return p;
    endfunction

    // First byte lane and lane count of a transfer
    function automatic int lane_first(addr_t a, logic [2:0] sz);
        int off;
        off = int'(a[1:0]);
        if (sz == HSIZE_BYTE) begin
            return off;
        end
        if (sz == HSIZE_HALF) begin
            return off & 2;
        end
        return 0;
    endfunction

    function automatic int lane_count(logic [2:0] sz);
        if (sz == HSIZE_BYTE) begin
            return 1;
        end
        if (sz == HSIZE_HALF) begin
            return 2;
        end
        return 4;
    endfunction

    // Expected HRDATA from the model, unselected lanes zero
    function automatic word_t ref_rdata(addr_t a, logic [2:0] sz);
        word_t w;
        int    base;
        int    first;
        base  = int'(a[11:0]) & ~3;
        first = lane_first(a, sz);
        w     = '0;
        for (int i = 0; i < 4; i++) begin
            if (i >= first && i < first + lane_count(sz)) begin
                w[i*8 +: 8] = mem_model[base + i];
            end
        end
        return w;
    endfunction

    task automatic model_write(addr_t a, logic [2:0] sz, word_t d, chk_t c);
        int base;
        int first;
        base  = int'(a[11:0]) & ~3;
        first = lane_first(a, sz);
        for (int i = first; i < first + lane_count(sz); i++) begin
            mem_model[base + i] = d[i*8 +: 8];
        end
        chk_model[a[11:2]] = c;
    endtask

    task automatic check_value(logic [31:0] got, logic [31:0] exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // Falling edge is away from both the DUT clock edge and the drive time
    always @(negedge s_clk) begin
        if (mon_en) begin
            check_value(32'(hready), 32'(exp_ready), "HREADY");
            check_value(32'(hresp), 32'(exp_resp), "HRESP");
            if (exp_rd) begin
                check_value(hrdata, exp_data, "HRDATA");
                check_value(32'(hrchecksum), 32'(exp_chk), "HRCHECKSUM");
            end
        end
    end

    task automatic next_cycle();
        @(posedge s_clk);
        #1;
        exp_rd    = 1'b0;
        exp_ready = 1'b1;
        exp_resp  = 1'b0;
    endtask

    task automatic drive_addr(logic sel, logic [1:0] tr, logic wr, addr_t a,
                              logic [2:0] sz, par_t flip);
        logic [31:0] r;
        r         = $random(seed);
        hsel      = sel;
        htrans    = tr;
        hwrite    = wr;
        haddr     = a;
        hsize     = sz;
        hburst    = 3'b000;
        hmastlock = 1'b0;
        hprot     = r[3:0];
        hparity   = calc_parity(a, tr, sz, 3'b000, r[3:0], wr, 1'b0) ^ flip;
    endtask

    task automatic drive_idle();
        drive_addr(1'b1, HTRANS_IDLE, 1'b0, '0, HSIZE_WORD, '0);
    endtask

    task automatic expect_read(addr_t a, logic [2:0] sz);
        exp_rd   = 1'b1;
        exp_data = ref_rdata(a, sz);
        exp_chk  = chk_model[a[11:2]];
    endtask

    task automatic do_write(addr_t a, logic [2:0] sz, word_t d, chk_t c);
        next_cycle();
        drive_addr(1'b1, HTRANS_NONSEQ, 1'b1, a, sz, '0);
        next_cycle();
        drive_idle();
        hwdata     = d;
        hwchecksum = c;
        model_write(a, sz, d, c);
    endtask

    task automatic do_read(addr_t a, logic [2:0] sz);
        next_cycle();
        drive_addr(1'b1, HTRANS_NONSEQ, 1'b0, a, sz, '0);
        next_cycle();
        drive_idle();
        expect_read(a, sz);
    endtask

    // Write data phase overlaps the read address phase of the same word
    task automatic write_then_read(addr_t a, logic [2:0] sz, word_t d, chk_t c);
        next_cycle();
        drive_addr(1'b1, HTRANS_NONSEQ, 1'b1, a, sz, '0);
        next_cycle();
        drive_addr(1'b1, HTRANS_NONSEQ, 1'b0, a, HSIZE_WORD, '0);
        hwdata     = d;
        hwchecksum = c;
        model_write(a, sz, d, c);
        next_cycle();
        drive_idle();
        expect_read(a, HSIZE_WORD);
    endtask

    task automatic bad_parity_write(addr_t a, int bit_no);
        next_cycle();
        drive_addr(1'b1, HTRANS_NONSEQ, 1'b1, a, HSIZE_WORD, par_t'(1) << bit_no);
        next_cycle();
        drive_idle();
        hwdata     = $random(seed);
        hwchecksum = ~chk_model[a[11:2]];
        exp_ready  = 1'b0;
        exp_resp   = 1'b1;
        next_cycle();
        exp_resp   = 1'b1;
    endtask

    task automatic report_test(int num, string name, int errs_before);
        if (errors == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAILED with %0d mismatches", num, name, errors - errs_before);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT did not finish the planned transfers in time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int          e0;
        logic [31:0] r;
        addr_t       a;
        s_clk      = 1'b0;
        s_resetn   = 1'b0;
        mon_en     = 1'b0;
        exp_rd     = 1'b0;
        exp_data   = '0;
        exp_chk    = '0;
        exp_ready  = 1'b1;
        exp_resp   = 1'b0;
        hwdata     = '0;
        hwchecksum = '0;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        drive_idle();
        repeat (2) @(posedge s_clk);
        #1;
        s_resetn = 1'b1;
        mon_en   = 1'b1;

        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            r          = $random(seed);
            wr_addr[i] = {20'h0, 2'b00, r[7:0], 2'b00};
            r          = $random(seed);
            do_write(wr_addr[i], HSIZE_WORD, r, r[6:0] ^ 7'h2a);
        end
        for (int i = 0; i < 16; i++) begin
            do_read(wr_addr[i], HSIZE_WORD);
        end
        report_test(1, "word write and read", e0);

        e0 = errors;
        for (int w = 0; w < 4; w++) begin
            a = 32'h0000_0400 + 32'(w * 4);
            do_write(a, HSIZE_WORD, $random(seed), 7'(w));
            for (int b = 0; b < 4; b++) begin
                r = $random(seed);
                do_write(a + 32'(b), HSIZE_BYTE, r, r[6:0]);
            end
            // Lower half on the first two words, upper half on the others
            r = $random(seed);
            do_write(a + 32'(w & 2), HSIZE_HALF, r, r[6:0]);
            for (int b = 0; b < 4; b++) begin
                do_read(a + 32'(b), HSIZE_BYTE);
            end
            do_read(a, HSIZE_HALF);
            do_read(a + 32'd2, HSIZE_HALF);
            do_read(a, HSIZE_WORD);
        end
        report_test(2, "sized writes and reads", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = 32'h0000_0800 + 32'(i * 4);
            do_write(a, HSIZE_WORD, $random(seed), 7'h11);
            r = $random(seed);
            write_then_read(a + 32'(r[1:0]), HSIZE_BYTE, $random(seed), r[14:8]);
            r = $random(seed);
            write_then_read(a, HSIZE_WORD, r, r[22:16]);
        end
        report_test(3, "write to read forwarding", e0);

        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            bad_parity_write(wr_addr[i], i);
            do_read(wr_addr[i], HSIZE_WORD);
        end
        report_test(4, "parity error response", e0);

        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            next_cycle();
            if (r[0]) begin
                drive_addr(1'b0, HTRANS_NONSEQ, 1'b1, wr_addr[r[7:4]], HSIZE_WORD, '0);
            end else begin
                drive_addr(1'b1, HTRANS_IDLE, 1'b1, wr_addr[r[7:4]], HSIZE_WORD, '0);
            end
            hwdata     = $random(seed);
            hwchecksum = r[14:8];
        end
        for (int i = 0; i < 16; i++) begin
            do_read(wr_addr[i], HSIZE_WORD);
        end
        report_test(5, "idle and deselected cycles", e0);

        next_cycle();
        next_cycle();
        mon_en = 1'b0;
        $display("Summary: %0d checks, %0d mismatches, %0d of 5 tests with errors",
                 checks, errors, failed_tests);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/ahb_ram_pkg.sv
logic/ahb_phase_ctrl.sv
logic/ram_data_bank.sv
logic/ram_check_bank.sv
logic/ahb_resp_merge.sv
logic/ahb_ram_top.sv
dv/tb_ahb_ram.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, fail unless the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module tb_ahb_ram -o tb_ahb_ram_sim &&
./obj_dir/tb_ahb_ram_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }
